// File: Bender.yml
package:
  name: uart_rx

sources:
  - design/uart_rx_pkg.sv
  - design/uart_rx_sync.sv
  - design/uart_rx_des.sv
  - design/uart_rx_merge.sv
  - design/uart_rx_top.sv
  - target: test
    files:
      - dv/uart_rx_tb.sv

// File: all.f
design/uart_rx_pkg.sv
design/uart_rx_sync.sv
design/uart_rx_des.sv
design/uart_rx_merge.sv
design/uart_rx_top.sv
dv/uart_rx_tb.sv

// File: design/uart_rx_des.sv
// single channel uart deserializer
// start edge detect, baud and bit counters, byte out as a valid pulse
`default_nettype none

module uart_rx_des (
    // system
    input  wire                    clk,
    input  wire                    rst,
    // run time config
    input  wire uart_rx_pkg::bdr_t cfg_bdr,
    input  wire uart_rx_pkg::bdr_t cfg_smp,
    // synchronized serial line
    input  wire                    rxd,
    // byte stream, no ready
    output logic                   str_vld,
    output uart_rx_pkg::dat_t      str_dat
);

    // receiver states
    typedef enum logic {
        IDLE,
        SHIFT
    } des_state_t;

    // bit counter, counts 0 .. SHF_N-1
    typedef logic [$clog2(uart_rx_pkg::SHF_N)-1:0] cnt_t;

    des_state_t state;

    // start edge
    logic rxd_dly;
    logic rxd_edg;

    // baud timing
    uart_rx_pkg::bdr_t bdr_cnt;
    logic              bdr_end;
    logic              bdr_smp;

    // bit position within the frame
    cnt_t shf_cnt;
    logic shf_end;

    // data + stop, start falls off the end
    logic [uart_rx_pkg::DAT_W+uart_rx_pkg::STP_W-1:0] shf_dat;

    ////////////////////////////////////////////////////////////
    // start edge
    ////////////////////////////////////////////////////////////

    // delayed line, idles high
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rxd_dly <= 1'b1;
        end else begin
            rxd_dly <= rxd;
        end
    end

    // high then low
    assign rxd_edg = rxd_dly & ~rxd;

    ////////////////////////////////////////////////////////////
    // baud counter
    ////////////////////////////////////////////////////////////

    // wraps every cfg_bdr+1 clocks while shifting
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bdr_cnt <= '0;
        end else if (state == SHIFT) begin
            bdr_cnt <= bdr_end ? '0 : bdr_cnt + uart_rx_pkg::bdr_t'(1);
        end else begin
            bdr_cnt <= '0;
        end
    end

    assign bdr_end = bdr_cnt == cfg_bdr;
    assign bdr_smp = bdr_cnt == cfg_smp;

    ////////////////////////////////////////////////////////////
    // frame fsm
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            shf_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (rxd_edg) begin
                        shf_cnt <= '0;
                        state   <= SHIFT;
                    end
                end
                SHIFT: begin
                    // leave on the stop bit sample, line is high again
                    if (shf_end) begin
                        if (bdr_smp) begin
                            shf_cnt <= '0;
                            state   <= IDLE;
                        end
                    end else if (bdr_end) begin
                        shf_cnt <= shf_cnt + cnt_t'(1);
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign shf_end = shf_cnt == cnt_t'(uart_rx_pkg::SHF_N - 1);

    // valid one clock after the stop sample
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            str_vld <= 1'b0;
        end else begin
            str_vld <= (state == SHIFT) & shf_end & bdr_smp;
        end
    end

    ////////////////////////////////////////////////////////////
    // shift register
    ////////////////////////////////////////////////////////////

    // lsb first, shifts right at each sample
    always_ff @(posedge clk) begin
        if ((state == SHIFT) && bdr_smp) begin
            shf_dat <= {rxd, shf_dat[uart_rx_pkg::DAT_W+uart_rx_pkg::STP_W-1:1]};
        end
    end

    // byte holds until next frame samples
    assign str_dat = shf_dat[uart_rx_pkg::DAT_W-1:0];

    // a second pulse needs a whole new frame
    assert property (@(posedge clk) disable iff (rst) str_vld |=> !str_vld);

    // counter stays inside the frame
    assert property (@(posedge clk) disable iff (rst)
        int'(shf_cnt) <= uart_rx_pkg::SHF_N - 1);

endmodule : uart_rx_des

`default_nettype wire

// File: design/uart_rx_merge.sv
// channel merger, one holding slot per channel with overrun flags
// round robin grant onto a four phase req/ack port
`default_nettype none

module uart_rx_merge (
    // system
    input  wire                        clk,
    input  wire                        rst,
    // byte streams from the deserializers
    input  wire uart_rx_pkg::chn_vec_t str_vld,
    input  wire uart_rx_pkg::dat_t     str_dat [uart_rx_pkg::CHN],
    // handshake port
    output logic                       req,
    input  wire                        ack,
    output uart_rx_pkg::dat_t          out_dat,
    output uart_rx_pkg::chn_t          out_chn,
    // sticky overrun per channel
    output uart_rx_pkg::chn_vec_t      ovr
);

    // handshake phases
    typedef enum logic [1:0] {
        H_IDLE,
        H_REQ,
        H_WAIT_LOW
    } hs_state_t;

    hs_state_t hs_state;

    // holding slots
    uart_rx_pkg::dat_t     slot_dat [uart_rx_pkg::CHN];
    uart_rx_pkg::chn_vec_t slot_ful;
    uart_rx_pkg::chn_vec_t slot_clr;
    uart_rx_pkg::chn_vec_t slot_wen;
    uart_rx_pkg::chn_vec_t slot_drp;

    // arbiter
    uart_rx_pkg::chn_t rr_lst;
    uart_rx_pkg::chn_t gnt_chn;
    logic              gnt_vld;
    logic              gnt_go;

    ////////////////////////////////////////////////////////////
    // holding slots
    ////////////////////////////////////////////////////////////

    // served slot frees up when ack is seen
    always_comb begin
        slot_clr = '0;
        if ((hs_state == H_REQ) && ack) begin
            slot_clr[out_chn] = 1'b1;
        end
    end

    // write if empty or emptied this cycle, else drop
    assign slot_wen = str_vld & (~slot_ful | slot_clr);
    assign slot_drp = str_vld & slot_ful & ~slot_clr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot_ful <= '0;
            ovr      <= '0;
        end else begin
            slot_ful <= (slot_ful & ~slot_clr) | slot_wen;
            // sticks until reset
            ovr      <= ovr | slot_drp;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < uart_rx_pkg::CHN; i++) begin
            if (slot_wen[i]) begin
                slot_dat[i] <= str_dat[i];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // round robin
    ////////////////////////////////////////////////////////////

    // first full slot after the last grant
    // walk down so the nearest one wins, rr_lst itself comes last
    always_comb begin
        gnt_vld = 1'b0;
        gnt_chn = rr_lst;
        for (int k = uart_rx_pkg::CHN; k >= 1; k--) begin
            if (slot_ful[uart_rx_pkg::chn_t'(rr_lst + k)]) begin
                gnt_vld = 1'b1;
                gnt_chn = uart_rx_pkg::chn_t'(rr_lst + k);
            end
        end
    end

    // grant only from idle, with ack already low
    assign gnt_go = (hs_state == H_IDLE) & gnt_vld & ~ack;

    ////////////////////////////////////////////////////////////
    // handshake fsm
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hs_state <= H_IDLE;
            // channel 0 goes first after reset
            rr_lst   <= uart_rx_pkg::chn_t'(uart_rx_pkg::CHN - 1);
        end else begin
            case (hs_state)
                H_IDLE: begin
                    if (gnt_go) begin
                        hs_state <= H_REQ;
                        rr_lst   <= gnt_chn;
                    end
                end
                H_REQ: begin
                    if (ack) begin
                        hs_state <= H_WAIT_LOW;
                    end
                end
                H_WAIT_LOW: begin
                    if (!ack) begin
                        hs_state <= H_IDLE;
                    end
                end
                default: hs_state <= H_IDLE;
            endcase
        end
    end

    // output latched at grant, steady through the handshake
    always_ff @(posedge clk) begin
        if (gnt_go) begin
            out_dat <= slot_dat[gnt_chn];
            out_chn <= gnt_chn;
        end
    end

    assign req = hs_state == H_REQ;

    // payload stable across the request
    assert property (@(posedge clk) disable iff (rst)
        req |=> !req || ($stable(out_dat) && $stable(out_chn)));

    // no new request until ack was seen low
    assert property (@(posedge clk) disable iff (rst) $rose(req) |-> !$past(ack));

endmodule : uart_rx_merge

`default_nettype wire

// File: design/uart_rx_pkg.sv
// uart receive subsystem, shared widths and types
// channel count, frame shape and vector typedefs
`default_nettype none

package uart_rx_pkg;

    ////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////

    // number of serial channels
    localparam int unsigned CHN = 4;
    // channel index width, CHN must stay a power of two
    localparam int unsigned CHN_W = 2;

    // baud counter and config width
    localparam int unsigned BDR_W = 8;

    // frame shape
    localparam int unsigned DAT_W = 8;
    localparam int unsigned STP_W = 1;
    // start + data + stop
    localparam int unsigned SHF_N = 1 + DAT_W + STP_W;

    ////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////

    // baud count, baud period or sample position
    typedef logic [BDR_W-1:0] bdr_t;

    // one received byte
    typedef logic [DAT_W-1:0] dat_t;

    // channel number
    typedef logic [CHN_W-1:0] chn_t;

    // one bit per channel
    // lines, valids, full flags, overrun flags
    typedef logic [CHN-1:0] chn_vec_t;

endpackage : uart_rx_pkg

`default_nettype wire

// File: design/uart_rx_sync.sv
// input synchronizer for the serial lines
// two flops per line, reset to the idle level
`default_nettype none

module uart_rx_sync (
    // system
    input  wire                   clk,
    input  wire                   rst,
    // asynchronous lines
    input  wire uart_rx_pkg::chn_vec_t rxd,
    // lines in the clk domain
    output uart_rx_pkg::chn_vec_t rxd_sync
);

    // first stage, may go metastable
    uart_rx_pkg::chn_vec_t rxd_meta;

    ////////////////////////////////////////////////////////////
    // two flop stages
    ////////////////////////////////////////////////////////////

    // reset to high, idle level
    // no false start edge comes out of reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rxd_meta <= '1;
        end else begin
            rxd_meta <= rxd;
        end
    end

    // second stage settles the first
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rxd_sync <= '1;
        end else begin
            rxd_sync <= rxd_meta;
        end
    end

endmodule : uart_rx_sync

`default_nettype wire

// File: design/uart_rx_top.sv
// four channel uart receiver top
// synchronizer, per channel deserializers and the req/ack merger
`default_nettype none

module uart_rx_top (
    // system
    input  wire                        clk,
    input  wire                        rst,
    // serial lines, idle high
    input  wire uart_rx_pkg::chn_vec_t rxd,
    // shared config
    input  wire uart_rx_pkg::bdr_t     cfg_bdr,
    input  wire uart_rx_pkg::bdr_t     cfg_smp,
    // byte port
    output logic                       req,
    input  wire                        ack,
    output uart_rx_pkg::dat_t          out_dat,
    output uart_rx_pkg::chn_t          out_chn,
    output uart_rx_pkg::chn_vec_t      ovr
);

    // lines in the clk domain
    wire uart_rx_pkg::chn_vec_t rxd_sync;

    // deserializer outputs
    wire uart_rx_pkg::chn_vec_t str_vld;
    wire uart_rx_pkg::dat_t     str_dat [uart_rx_pkg::CHN];

    uart_rx_sync sync_i (
        .clk      (clk),
        .rst      (rst),
        .rxd      (rxd),
        .rxd_sync (rxd_sync)
    );

    // one deserializer per line
    for (genvar i = 0; i < uart_rx_pkg::CHN; i++) begin : des_g
        uart_rx_des des_i (
            .clk     (clk),
            .rst     (rst),
            .cfg_bdr (cfg_bdr),
            .cfg_smp (cfg_smp),
            .rxd     (rxd_sync[i]),
            .str_vld (str_vld[i]),
            .str_dat (str_dat[i])
        );
    end

    uart_rx_merge merge_i (
        .clk     (clk),
        .rst     (rst),
        .str_vld (str_vld),
        .str_dat (str_dat),
        .req     (req),
        .ack     (ack),
        .out_dat (out_dat),
        .out_chn (out_chn),
        .ovr     (ovr)
    );

endmodule : uart_rx_top

`default_nettype wire

// File: dv/uart_rx_tb.sv
// testbench for the four channel uart receiver
// serial frame drivers, ack responder, handshake assertions and byte checks
`default_nettype none

module uart_rx_tb;

    timeunit 1ns;
    timeprecision 100ps;

    // wait limit in clocks
    localparam int TMO_CYC = 400;

    logic                  clk;
    logic                  rst;
    uart_rx_pkg::chn_vec_t rxd;
    uart_rx_pkg::bdr_t     cfg_bdr;
    uart_rx_pkg::bdr_t     cfg_smp;
    logic                  req;
    logic                  ack;
    uart_rx_pkg::dat_t     out_dat;
    uart_rx_pkg::chn_t     out_chn;
    uart_rx_pkg::chn_vec_t ovr;

    // scoreboard
    uart_rx_pkg::dat_t     exp_q [uart_rx_pkg::CHN][$];
    uart_rx_pkg::chn_vec_t ovr_exp;
    int                    error_cnt;
    int                    timeout_cnt;
    logic [31:0]           lcg_state;

    uart_rx_top dut_i (
        .clk     (clk),
        .rst     (rst),
        .rxd     (rxd),
        .cfg_bdr (cfg_bdr),
        .cfg_smp (cfg_smp),
        .req     (req),
        .ack     (ack),
        .out_dat (out_dat),
        .out_chn (out_chn),
        .ovr     (ovr)
    );

    // 100 ns clock
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    // byte from the upper bits of an lcg step
    function automatic uart_rx_pkg::dat_t lcg_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        error_cnt++;
        $display("[FAIL] %0t %s expected %0h got %0h", $time, name, exp, got);
    endtask

    // start bit low, lsb first data, stop bit high
    // caller sits 10 ns past an edge
    task automatic send_frame(input int c, input uart_rx_pkg::dat_t b);
        logic [uart_rx_pkg::SHF_N-1:0] bits;
        bits = {1'b1, b, 1'b0};
        for (int i = 0; i < uart_rx_pkg::SHF_N; i++) begin
            rxd[c] = bits[i];
            repeat (int'(cfg_bdr) + 1) @(posedge clk);
            #10;
        end
    endtask

    // byte against the head of its channel queue at the ack rise
    task automatic check_byte(input int exp_chn);
        uart_rx_pkg::dat_t exp;
        assert (int'(out_chn) == exp_chn)
            else report_mismatch("out_chn", exp_chn, out_chn);
        if (exp_q[out_chn].size() == 0) begin
            error_cnt++;
            $display("%0t: byte %0h on channel %0d was never sent", $time, out_dat, out_chn);
        end else begin
            exp = exp_q[out_chn].pop_front();
            assert (out_dat == exp) else report_mismatch("out_dat", exp, out_dat);
        end
    endtask

    // consumer side of the four phase port
    // ack stays high for hold cycles after req falls
    task automatic take_byte(input int exp_chn, input int dly, input int hold);
        int n;
        n = 0;
        while (!req && n < TMO_CYC) begin
            @(posedge clk);
            #10;
            n++;
        end
        if (!req) begin
            timeout_cnt++;
            $display("%0t: timed out waiting for req to rise", $time);
        end else begin
            repeat (dly) begin
                @(posedge clk);
                #10;
            end
            ack = 1'b1;
            check_byte(exp_chn);
            n = 0;
            while (req && n < TMO_CYC) begin
                @(posedge clk);
                #10;
                n++;
            end
            if (req) begin
                timeout_cnt++;
                $display("%0t: timed out waiting for req to fall", $time);
            end
            repeat (hold) begin
                @(posedge clk);
                #10;
            end
            ack = 1'b0;
        end
    endtask

    task automatic wait_ovr(input int c);
        int n;
        n = 0;
        while (!ovr[c] && n < TMO_CYC) begin
            @(posedge clk);
            #10;
            n++;
        end
        if (!ovr[c]) begin
            timeout_cnt++;
            $display("%0t: timed out waiting for overrun on channel %0d", $time, c);
        end
    endtask

    // no request and only the expected flags
    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #10;
            assert (req == 1'b0) else report_mismatch("req", 0, req);
            assert (ovr == ovr_exp) else report_mismatch("ovr", ovr_exp, ovr);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // handshake and flag rules
    ////////////////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (rst) $fell(req) |-> $past(ack))
        else begin
            error_cnt++;
            $display("%0t: req fell before ack was seen high", $time);
        end

    assert property (@(posedge clk) disable iff (rst)
        (req || ack) && $past(req || ack) |-> $stable(out_dat) && $stable(out_chn))
        else begin
            error_cnt++;
            $display("%0t: out_dat or out_chn changed during a handshake", $time);
        end

    assert property (@(posedge clk) disable iff (rst) $rose(req) |-> !$past(ack))
        else begin
            error_cnt++;
            $display("%0t: req rose while ack was still high", $time);
        end

    // sticky until reset
    assert property (@(posedge clk) disable iff (rst) ($past(ovr) & ~ovr) == '0)
        else begin
            error_cnt++;
            $display("%0t: an overrun flag cleared without reset", $time);
        end

    assert property (@(posedge clk) disable iff (rst) (ovr & ~ovr_exp) == '0)
        else begin
            error_cnt++;
            $display("[FAIL] %0t ovr expected %b got %b", $time, ovr_exp, ovr);
        end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        uart_rx_pkg::dat_t bb [uart_rx_pkg::CHN];
        rst         = 1'b1;
        rxd         = '1;
        ack         = 1'b0;
        cfg_bdr     = 8'd3;
        cfg_smp     = 8'd1;
        ovr_exp     = '0;
        error_cnt   = 0;
        timeout_cnt = 0;
        lcg_state   = 32'd67620;
        repeat (5) @(posedge clk);
        #10;
        rst = 1'b0;

        // quiet lines keep the port quiet
        check_idle(20);

        // one frame per channel in turn
        for (int c = 0; c < uart_rx_pkg::CHN; c++) begin
            bb[c] = lcg_byte();
            exp_q[c].push_back(bb[c]);
            send_frame(c, bb[c]);
            take_byte(c, int'(lcg_byte() % 4), int'(lcg_byte() % 3));
        end

        // all lines start together
        // pointer is back at its reset value
        for (int c = 0; c < uart_rx_pkg::CHN; c++) begin
            bb[c] = lcg_byte();
            exp_q[c].push_back(bb[c]);
        end
        fork
            send_frame(0, bb[0]);
            send_frame(1, bb[1]);
            send_frame(2, bb[2]);
            send_frame(3, bb[3]);
        join
        // ack lingers while other slots are still full
        for (int c = 0; c < uart_rx_pkg::CHN; c++) begin
            take_byte(c, int'(lcg_byte() % 4), 3);
        end

        // back to back frames on channel 1 with prompt ack
        for (int k = 0; k < 3; k++) begin
            bb[k] = lcg_byte();
            exp_q[1].push_back(bb[k]);
        end
        fork
            begin
                for (int k = 0; k < 3; k++) begin
                    send_frame(1, bb[k]);
                end
            end
            begin
                for (int k = 0; k < 3; k++) begin
                    take_byte(1, 0, 0);
                end
            end
        join
        check_idle(10);

        // ack held off so the second byte on channel 2 is dropped
        bb[0] = lcg_byte();
        bb[1] = lcg_byte();
        exp_q[2].push_back(bb[0]);
        ovr_exp[2] = 1'b1;
        send_frame(2, bb[0]);
        send_frame(2, bb[1]);
        wait_ovr(2);
        take_byte(2, 2, 2);
        check_idle(60);

        // leftovers
        for (int c = 0; c < uart_rx_pkg::CHN; c++) begin
            if (exp_q[c].size() != 0) begin
                error_cnt++;
                $display("channel %0d still has %0d undelivered bytes", c, exp_q[c].size());
            end
        end
        assert (ovr == ovr_exp) else report_mismatch("ovr", ovr_exp, ovr);

        $display("errors: %0d, timeouts: %0d", error_cnt, timeout_cnt);
        if (error_cnt == 0 && timeout_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule : uart_rx_tb

`default_nettype wire
